//--- logic/dmac_consts.svh
`ifndef DMAC_CONSTS_SVH
`define DMAC_CONSTS_SVH

// register offsets within the slave window
`define DMAC_CONFIG_OFS 12'h030
`define DMAC_SRC_OFS    12'h100
`define DMAC_DST_OFS    12'h104
`define DMAC_CTRL_OFS   12'h10C
`define DMAC_CHCFG_OFS  12'h110

`define HRESP_OKAY  2'b00
`define HRESP_ERROR 2'b01

`define BUF_DEPTH  16
`define WORD_BYTES 4

// control register fields
`define TS_MSB 11
`define BS_LSB 12
`define BS_MSB 14

`define CH_EN_BIT    0
`define INT_MASK_BIT 1
`define INT_PEND_BIT 2

`endif

//--- logic/dmac_pkg.sv
package dmac_pkg;

   typedef logic [31:0] word_t;
   typedef logic [11:0] reg_offset_t;
   typedef logic [11:0] xfer_size_t;   // bytes left in the transfer
   typedef logic [2:0]  burst_code_t;
   typedef logic [4:0]  beat_cnt_t;    // 0 to 16

   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,
      TRANS_BUSY   = 2'b01,
      TRANS_NONSEQ = 2'b10,
      TRANS_SEQ    = 2'b11
   } htrans_t;

   // AHB encodings, wrapping bursts never issued
   typedef enum logic [2:0] {
      BURST_SINGLE = 3'b000,
      BURST_INCR   = 3'b001,
      BURST_INCR4  = 3'b011,
      BURST_INCR8  = 3'b101,
      BURST_INCR16 = 3'b111
   } hburst_t;

   typedef enum logic [2:0] {
      MS_IDLE, MS_REQ, MS_RADDR, MS_RDATA, MS_WADDR, MS_WDATA
   } master_state_t;

endpackage

//--- logic/dmac_reg_slave.sv
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_reg_slave import dmac_pkg::*; (
   input  logic        HCLK,
   input  logic        HRESETn,
   input  logic        hsel,
   input  logic        hready,
   input  logic        hwrite,
   input  htrans_t     htrans,
   input  word_t       haddr,
   input  word_t       hwdata,
   input  logic        size_dec,
   input  logic        done,
   output word_t       hrdata,
   output logic [1:0]  hresp,
   output logic        hreadyout,
   output logic        run,
   output word_t       src_base,
   output word_t       dst_base,
   output xfer_size_t  xfer_size,
   output burst_code_t burst_code,
   output logic        dmacintr
);

   typedef enum logic [1:0] {S_ADDR, S_DATA, S_ERROR} slave_state_t;

   slave_state_t state;
   slave_state_t state_nxt;
   reg_offset_t  ofs_q;
   logic         wr_q;
   logic         glb_en;
   logic         ch_en;
   logic         int_mask;
   logic         int_pend;
   logic         addr_valid;
   logic         mapped;
   logic         bad_wr;
   logic         reg_wr;
   logic         wr_ctrl;
   logic         wr_chcfg;

   assign addr_valid = hsel && hready && (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ);

   always_comb begin
      case (ofs_q)
         `DMAC_CONFIG_OFS, `DMAC_SRC_OFS, `DMAC_DST_OFS,
         `DMAC_CTRL_OFS, `DMAC_CHCFG_OFS: mapped = 1'b1;
         default:                         mapped = 1'b0;
      endcase
   end

   assign bad_wr   = (state == S_DATA) && wr_q && !mapped;   // first error cycle
   assign reg_wr   = (state == S_DATA) && wr_q && mapped && hready;
   assign wr_ctrl  = reg_wr && (ofs_q == `DMAC_CTRL_OFS);
   assign wr_chcfg = reg_wr && (ofs_q == `DMAC_CHCFG_OFS);

   always_comb begin
      state_nxt = state;
      case (state)
         S_DATA: begin
            if (bad_wr)
               state_nxt = S_ERROR;
            else if (hready)
               state_nxt = addr_valid ? S_DATA : S_ADDR;
         end
         S_ADDR, S_ERROR: state_nxt = addr_valid ? S_DATA : S_ADDR;
         default:         state_nxt = S_ADDR;
      endcase
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         state <= S_ADDR;
         ofs_q <= '0;
         wr_q  <= 1'b0;
      end else begin
         state <= state_nxt;
         if (addr_valid) begin
            ofs_q <= haddr[11:0];
            wr_q  <= hwrite;
         end
      end
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         glb_en     <= 1'b0;
         src_base   <= '0;
         dst_base   <= '0;
         xfer_size  <= '0;
         burst_code <= '0;
         ch_en      <= 1'b0;
         int_mask   <= 1'b0;
         int_pend   <= 1'b0;
      end else begin
         if (reg_wr && ofs_q == `DMAC_CONFIG_OFS)
            glb_en <= hwdata[0];
         if (reg_wr && ofs_q == `DMAC_SRC_OFS)
            src_base <= hwdata;
         if (reg_wr && ofs_q == `DMAC_DST_OFS)
            dst_base <= hwdata;
         // bus write beats the countdown
         if (wr_ctrl) begin
            xfer_size  <= hwdata[`TS_MSB:0];
            burst_code <= hwdata[`BS_MSB:`BS_LSB];
         end else if (size_dec) begin
            xfer_size <= xfer_size - xfer_size_t'(`WORD_BYTES);
         end
         if (wr_chcfg) begin
            ch_en    <= hwdata[`CH_EN_BIT];
            int_mask <= hwdata[`INT_MASK_BIT];
            int_pend <= hwdata[`INT_PEND_BIT];
         end else if (done) begin
            ch_en    <= 1'b0;
            int_pend <= 1'b1;
         end
      end
   end

   always_comb begin
      hrdata = '0;
      if (state == S_DATA && !wr_q) begin
         case (ofs_q)
            `DMAC_CONFIG_OFS: hrdata[0] = glb_en;
            `DMAC_SRC_OFS:    hrdata = src_base;
            `DMAC_DST_OFS:    hrdata = dst_base;
            `DMAC_CTRL_OFS: begin
               hrdata[`TS_MSB:0]       = xfer_size;
               hrdata[`BS_MSB:`BS_LSB] = burst_code;
            end
            `DMAC_CHCFG_OFS: begin
               hrdata[`CH_EN_BIT]    = ch_en;
               hrdata[`INT_MASK_BIT] = int_mask;
               hrdata[`INT_PEND_BIT] = int_pend;
            end
            default: hrdata = '0;   // unmapped reads return zero
         endcase
      end
   end

   assign hresp     = (bad_wr || state == S_ERROR) ? `HRESP_ERROR : `HRESP_OKAY;
   assign hreadyout = !bad_wr;
   assign run       = glb_en && ch_en;
   assign dmacintr  = int_pend && int_mask;

endmodule

//--- logic/dmac_channel_ctrl.sv
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_channel_ctrl import dmac_pkg::*; (
   input  logic        HCLK,
   input  logic        HRESETn,
   input  logic        run,
   input  logic        hready,
   input  logic        hgrant,
   input  word_t       src_base,
   input  word_t       dst_base,
   input  xfer_size_t  xfer_size,
   input  burst_code_t burst_code,
   output logic        size_dec,
   output logic        done,
   output logic        hbusreq,
   output logic        buf_clear,
   output htrans_t     trans,
   output word_t       addr,
   output logic        write,
   output hburst_t     burst
);

   master_state_t state;
   logic          grant_q;
   word_t         src_addr;
   word_t         dst_addr;
   beat_cnt_t     rd_cnt;
   beat_cnt_t     wr_cnt;
   beat_cnt_t     len_q;
   hburst_t       burst_q;
   beat_cnt_t     prog_len;
   hburst_t       prog_burst;
   logic [9:0]    words_left;
   logic          last_rd;
   logic          last_wr;

   assign words_left = xfer_size[11:2];
   assign last_rd    = (rd_cnt == len_q - 5'd1);
   assign last_wr    = (wr_cnt == len_q - 5'd1);

   always_comb begin
      case (burst_code)
         3'd0: begin
            prog_len   = 5'd1;
            prog_burst = BURST_SINGLE;
         end
         3'd1: begin
            prog_len   = 5'd4;
            prog_burst = BURST_INCR4;
         end
         3'd2: begin
            prog_len   = 5'd8;
            prog_burst = BURST_INCR8;
         end
         default: begin
            prog_len   = beat_cnt_t'(`BUF_DEPTH);
            prog_burst = BURST_INCR16;
         end
      endcase
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn)
         grant_q <= 1'b0;
      else
         grant_q <= hgrant;
   end

   // nothing moves while the bus is stalled
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         state    <= MS_IDLE;
         src_addr <= '0;
         dst_addr <= '0;
         rd_cnt   <= '0;
         wr_cnt   <= '0;
         len_q    <= '0;
         burst_q  <= BURST_SINGLE;
      end else if (hready) begin
         case (state)
            MS_IDLE: begin
               if (run && words_left != '0) begin
                  src_addr <= {src_base[31:2], 2'b00};
                  dst_addr <= {dst_base[31:2], 2'b00};
                  state    <= MS_REQ;
               end
            end
            MS_REQ: begin
               if (grant_q) begin
                  if (words_left < {5'd0, prog_len}) begin   // tail burst
                     len_q   <= words_left[4:0];
                     burst_q <= BURST_INCR;
                  end else begin
                     len_q   <= prog_len;
                     burst_q <= prog_burst;
                  end
                  rd_cnt <= '0;
                  wr_cnt <= '0;
                  state  <= MS_RADDR;
               end
            end
            MS_RADDR: begin
               src_addr <= src_addr + word_t'(`WORD_BYTES);
               rd_cnt   <= rd_cnt + 5'd1;
               if (last_rd)
                  state <= MS_RDATA;
            end
            MS_RDATA: state <= MS_WADDR;   // last read data lands
            MS_WADDR: begin
               dst_addr <= dst_addr + word_t'(`WORD_BYTES);
               wr_cnt   <= wr_cnt + 5'd1;
               if (last_wr)
                  state <= MS_WDATA;
            end
            MS_WDATA: state <= (words_left <= 10'd1) ? MS_IDLE : MS_REQ;
            default:  state <= MS_IDLE;
         endcase
      end
   end

   always_comb begin
      trans = TRANS_IDLE;
      if (state == MS_RADDR)
         trans = (rd_cnt == '0) ? TRANS_NONSEQ : TRANS_SEQ;
      else if (state == MS_WADDR)
         trans = (wr_cnt == '0) ? TRANS_NONSEQ : TRANS_SEQ;
   end

   assign write     = (state == MS_WADDR) || (state == MS_WDATA);
   assign addr      = write ? dst_addr : src_addr;
   assign burst     = burst_q;
   assign hbusreq   = (state != MS_IDLE);
   assign buf_clear = hready && (state == MS_REQ) && grant_q;

   // previous write beat completes on every accepted phase after the first
   assign size_dec = hready && ((state == MS_WADDR && wr_cnt != '0) || state == MS_WDATA);

   assign done = hready && ((state == MS_WDATA && words_left <= 10'd1) ||
                            (state == MS_IDLE && run && words_left == '0));

endmodule

//--- logic/dmac_burst_buffer.sv
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_burst_buffer import dmac_pkg::*; (
   input  logic  HCLK,
   input  logic  HRESETn,
   input  logic  buf_clear,
   input  logic  rd_beat,
   input  logic  wr_beat,
   input  word_t rd_data,
   output word_t wr_data
);

   localparam int IDX_W = $clog2(`BUF_DEPTH);

   word_t     mem [`BUF_DEPTH];
   beat_cnt_t fill_idx;
   beat_cnt_t drain_idx;

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         fill_idx  <= '0;
         drain_idx <= '0;
      end else if (buf_clear) begin
         fill_idx  <= '0;
         drain_idx <= '0;
      end else begin
         if (rd_beat)
            fill_idx <= fill_idx + 5'd1;
         if (wr_beat)
            drain_idx <= drain_idx + 5'd1;
      end
   end

   always_ff @(posedge HCLK) begin
      if (rd_beat)
         mem[fill_idx[IDX_W-1:0]] <= rd_data;
   end

   assign wr_data = mem[drain_idx[IDX_W-1:0]];   // word for the current write beat

endmodule

//--- logic/dmac_master_port.sv
`timescale 1ns/1ps

module dmac_master_port import dmac_pkg::*; (
   input  logic    HCLK,
   input  logic    HRESETn,
   input  logic    hready,
   input  htrans_t trans,
   input  word_t   addr,
   input  logic    write,
   input  hburst_t burst,
   input  word_t   hrdata,
   input  word_t   wr_data,
   output htrans_t m_htrans,
   output word_t   m_haddr,
   output logic    m_hwrite,
   output hburst_t m_hburst,
   output word_t   m_hwdata,
   output logic    rd_beat,
   output logic    wr_beat,
   output word_t   rd_data
);

   logic dp_valid;   // a data phase is in flight
   logic dp_write;

   // address phase straight from the control
   assign m_htrans = trans;
   assign m_haddr  = addr;
   assign m_hwrite = write;
   assign m_hburst = burst;

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         dp_valid <= 1'b0;
         dp_write <= 1'b0;
      end else if (hready) begin
         dp_valid <= (trans == TRANS_NONSEQ) || (trans == TRANS_SEQ);
         dp_write <= write;
      end
   end

   assign rd_beat  = hready && dp_valid && !dp_write;
   assign wr_beat  = hready && dp_valid && dp_write;
   assign rd_data  = hrdata;
   assign m_hwdata = (dp_valid && dp_write) ? wr_data : '0;

endmodule

//--- logic/dmac_top.sv
`timescale 1ns/1ps

module dmac_top import dmac_pkg::*; (
   input  logic       HCLK,
   input  logic       HRESETn,
   // slave side
   input  logic       hsel,
   input  logic       hready,
   input  logic       hwrite,
   input  htrans_t    htrans,
   input  word_t      haddr,
   input  word_t      hwdata,
   output word_t      s_hrdata,
   output logic [1:0] s_hresp,
   output logic       hreadyout,
   // master side
   input  word_t      hrdata,
   input  logic       hgrant,
   output logic       hbusreq,
   output htrans_t    m_htrans,
   output word_t      m_haddr,
   output logic       m_hwrite,
   output hburst_t    m_hburst,
   output word_t      m_hwdata,
   output logic       dmacintr
);

   logic        run;
   word_t       src_base;
   word_t       dst_base;
   xfer_size_t  xfer_size;
   burst_code_t burst_code;
   logic        size_dec;
   logic        done;
   logic        buf_clear;
   htrans_t     trans;
   word_t       addr;
   logic        write;
   hburst_t     burst;
   logic        rd_beat;
   logic        wr_beat;
   word_t       rd_data;
   word_t       wr_data;

   dmac_reg_slave u_reg_slave (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .hsel       (hsel),
      .hready     (hready),
      .hwrite     (hwrite),
      .htrans     (htrans),
      .haddr      (haddr),
      .hwdata     (hwdata),
      .size_dec   (size_dec),
      .done       (done),
      .hrdata     (s_hrdata),
      .hresp      (s_hresp),
      .hreadyout  (hreadyout),
      .run        (run),
      .src_base   (src_base),
      .dst_base   (dst_base),
      .xfer_size  (xfer_size),
      .burst_code (burst_code),
      .dmacintr   (dmacintr)
   );

   dmac_channel_ctrl u_channel_ctrl (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .run        (run),
      .hready     (hready),
      .hgrant     (hgrant),
      .src_base   (src_base),
      .dst_base   (dst_base),
      .xfer_size  (xfer_size),
      .burst_code (burst_code),
      .size_dec   (size_dec),
      .done       (done),
      .hbusreq    (hbusreq),
      .buf_clear  (buf_clear),
      .trans      (trans),
      .addr       (addr),
      .write      (write),
      .burst      (burst)
   );

   dmac_burst_buffer u_burst_buffer (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .buf_clear (buf_clear),
      .rd_beat   (rd_beat),
      .wr_beat   (wr_beat),
      .rd_data   (rd_data),
      .wr_data   (wr_data)
   );

   dmac_master_port u_master_port (
      .HCLK     (HCLK),
      .HRESETn  (HRESETn),
      .hready   (hready),
      .trans    (trans),
      .addr     (addr),
      .write    (write),
      .burst    (burst),
      .hrdata   (hrdata),
      .wr_data  (wr_data),
      .m_htrans (m_htrans),
      .m_haddr  (m_haddr),
      .m_hwrite (m_hwrite),
      .m_hburst (m_hburst),
      .m_hwdata (m_hwdata),
      .rd_beat  (rd_beat),
      .wr_beat  (wr_beat),
      .rd_data  (rd_data)
   );

endmodule

//--- test/dmac_assertions.sv
`timescale 1ns/1ps

module dmac_assertions import dmac_pkg::*; (
   input logic    HCLK,
   input logic    HRESETn,
   input logic    hready,
   input htrans_t m_htrans,
   input word_t   m_haddr,
   input logic    m_hwrite
);

   word_t last_addr;   // address of the last accepted beat

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn)
         last_addr <= '0;
      else if (hready && (m_htrans == TRANS_NONSEQ || m_htrans == TRANS_SEQ))
         last_addr <= m_haddr;
   end

   hold_on_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !hready |=> $stable(m_htrans) && $stable(m_haddr) && $stable(m_hwrite))
      else $error("address phase changed while hready was low");

   seq_increment: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (m_htrans == TRANS_SEQ) |-> (m_haddr == last_addr + 32'd4))
      else $error("SEQ address is not the previous address plus 4");

endmodule

bind dmac_master_port dmac_assertions u_assertions (.*);

//--- test/dmac_tb.sv
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_tb import dmac_pkg::*; ();

   localparam int MAX_WORDS    = 64;
   localparam int CYC_PER_WORD = 13;   // read + write beat, 3 waits each, grant and margin
   localparam int MAX_CYCLES   = 6 * 256 * CYC_PER_WORD;

   logic        HCLK;
   logic        HRESETn;
   logic        hsel;
   logic        hwrite;
   htrans_t     htrans;
   word_t       haddr;
   word_t       hwdata;
   word_t       s_hrdata;
   logic [1:0]  s_hresp;
   logic        hreadyout;
   logic        hready;
   logic        mem_ready;
   word_t       hrdata;
   logic        hgrant;
   logic        hbusreq;
   htrans_t     m_htrans;
   word_t       m_haddr;
   logic        m_hwrite;
   hburst_t     m_hburst;
   word_t       m_hwdata;
   logic        dmacintr;

   integer      seed;
   int          cycles;
   int          test_errs;
   int          pass_cnt;
   int          fail_cnt;
   word_t       ram [256];
   word_t       model [256];
   word_t       shadow [5];
   logic        stall_on;
   logic        dp_v;
   logic        dp_write;
   logic [7:0]  dp_idx;
   int          wait_left;
   int          gnt_wait;
   hburst_t     obs_code [$];
   int          obs_len [$];
   hburst_t     exp_code [$];
   int          exp_len [$];

   assign hready = mem_ready && hreadyout;   // one bus, both slaves

   dmac_top u_dmac_top (.*);

   always #5 HCLK = ~HCLK;

   always @(posedge HCLK) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, DMA never finished", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   // arbiter and memory slave, everything decided for the coming edge
   always @(negedge HCLK) begin
      if (!hbusreq) begin
         hgrant   = 1'b0;
         gnt_wait = rand_below(4);
      end else if (!hgrant) begin
         if (gnt_wait == 0)
            hgrant = 1'b1;
         else
            gnt_wait--;
      end
      if (!HRESETn) begin
         dp_v      = 1'b0;
         mem_ready = 1'b1;
      end else begin
         mem_ready = 1'b1;
         if (dp_v && wait_left > 0) begin
            mem_ready = 1'b0;
            wait_left--;
         end else if (dp_v && !dp_write) begin
            hrdata = ram[dp_idx];
         end
         if (mem_ready && hreadyout) begin
            if (dp_v && dp_write)
               ram[dp_idx] = m_hwdata;
            dp_v      = (m_htrans == TRANS_NONSEQ) || (m_htrans == TRANS_SEQ);
            dp_write  = m_hwrite;
            dp_idx    = m_haddr[9:2];
            wait_left = stall_on ? rand_below(4) : 0;
            if (m_htrans == TRANS_NONSEQ) begin
               obs_code.push_back(m_hburst);
               obs_len.push_back(1);
            end else if (m_htrans == TRANS_SEQ && obs_len.size() > 0) begin
               obs_len[obs_len.size()-1]++;
            end
         end
      end
   end

   task automatic check_val(input string name, input word_t exp, input word_t got);
      assert (got === exp) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, got);
         test_errs++;
      end
   endtask

   task automatic check_true(input string what, input logic cond);
      assert (cond === 1'b1) else begin
         $display("Error: %s", what);
         test_errs++;
      end
   endtask

   task automatic end_test(input string name);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s passed", name);
      end else begin
         fail_cnt++;
         $display("test %s failed with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic reg_write(input logic [11:0] ofs, input word_t data);
      @(negedge HCLK);
      while (!hready)
         @(negedge HCLK);
      hsel   = 1'b1;
      htrans = TRANS_NONSEQ;
      hwrite = 1'b1;
      haddr  = {20'd0, ofs};
      @(negedge HCLK);
      hsel   = 1'b0;
      htrans = TRANS_IDLE;
      hwdata = data;
      while (!hready)
         @(negedge HCLK);
   endtask

   task automatic reg_read(input logic [11:0] ofs, output word_t data);
      @(negedge HCLK);
      while (!hready)
         @(negedge HCLK);
      hsel   = 1'b1;
      htrans = TRANS_NONSEQ;
      hwrite = 1'b0;
      haddr  = {20'd0, ofs};
      @(negedge HCLK);
      hsel   = 1'b0;
      htrans = TRANS_IDLE;
      data   = s_hrdata;   // zero wait read
   endtask

   task automatic readback_all(input string name);
      word_t v;
      reg_read(`DMAC_CONFIG_OFS, v);
      check_val({name, " config"}, shadow[0] & 32'h1, v);
      reg_read(`DMAC_SRC_OFS, v);
      check_val({name, " src"}, shadow[1], v);
      reg_read(`DMAC_DST_OFS, v);
      check_val({name, " dst"}, shadow[2], v);
      reg_read(`DMAC_CTRL_OFS, v);
      check_val({name, " ctrl"}, shadow[3] & 32'h7fff, v);
      reg_read(`DMAC_CHCFG_OFS, v);
      check_val({name, " chcfg"}, shadow[4] & 32'h7, v);
   endtask

   task automatic run_copy(input string name, input burst_code_t bc, input logic stalls);
      int    n;
      int    src_w;
      int    dst_w;
      int    rem;
      int    len;
      logic  mask;
      word_t v;
      hburst_t code;
      n     = 1 + rand_below(MAX_WORDS);
      src_w = rand_below(128 - n);
      dst_w = 128 + rand_below(128 - n);
      mask  = rand_below(2) == 1;
      for (int i = 0; i < 256; i++) begin
         ram[i]   = $random(seed);
         model[i] = ram[i];
      end
      for (int i = 0; i < n; i++)
         model[dst_w + i] = model[src_w + i];
      // bursts as programmed, tail shortened to INCR
      exp_code.delete();
      exp_len.delete();
      rem = n;
      while (rem > 0) begin
         case (bc)
            3'd0:    begin len = 1;  code = BURST_SINGLE; end
            3'd1:    begin len = 4;  code = BURST_INCR4;  end
            3'd2:    begin len = 8;  code = BURST_INCR8;  end
            default: begin len = 16; code = BURST_INCR16; end
         endcase
         if (rem < len) begin
            len  = rem;
            code = BURST_INCR;
         end
         // read burst, then the write burst of the same shape
         for (int k = 0; k < 2; k++) begin
            exp_code.push_back(code);
            exp_len.push_back(len);
         end
         rem -= len;
      end
      obs_code.delete();
      obs_len.delete();
      stall_on = stalls;
      reg_write(`DMAC_CONFIG_OFS, 32'h1);
      reg_write(`DMAC_SRC_OFS, word_t'(src_w * 4));
      reg_write(`DMAC_DST_OFS, word_t'(dst_w * 4));
      reg_write(`DMAC_CTRL_OFS, {17'd0, bc, xfer_size_t'(n * 4)});
      reg_write(`DMAC_CHCFG_OFS, {30'd0, mask, 1'b1});
      while (!hbusreq)
         @(negedge HCLK);
      while (hbusreq)
         @(negedge HCLK);
      for (int i = 0; i < 256; i++)
         check_val($sformatf("%s mem[%0d]", name, i), model[i], ram[i]);
      check_val({name, " burst count"}, word_t'(exp_len.size()), word_t'(obs_len.size()));
      for (int i = 0; i < exp_len.size() && i < obs_len.size(); i++) begin
         check_val($sformatf("%s burst %0d hburst", name, i), word_t'(exp_code[i]),
                   word_t'(obs_code[i]));
         check_val($sformatf("%s burst %0d beats", name, i), word_t'(exp_len[i]),
                   word_t'(obs_len[i]));
      end
      reg_read(`DMAC_CHCFG_OFS, v);
      check_val({name, " chcfg after done"}, {29'd0, 1'b1, mask, 1'b0}, v);
      reg_read(`DMAC_CTRL_OFS, v);
      check_val({name, " ctrl after done"}, {17'd0, bc, 12'd0}, v);
      check_val({name, " dmacintr"}, word_t'(mask), word_t'(dmacintr));
      check_true("bus request still high after the transfer", !hbusreq);
      reg_write(`DMAC_CHCFG_OFS, 32'h0);   // clear pending
      stall_on = 1'b0;
      end_test(name);
   endtask

   initial begin
      seed      = 32'hb692;
      HCLK      = 1'b0;
      HRESETn   = 1'b0;
      hsel      = 1'b0;
      hwrite    = 1'b0;
      htrans    = TRANS_IDLE;
      haddr     = '0;
      hwdata    = '0;
      hrdata    = '0;
      hgrant    = 1'b0;
      mem_ready = 1'b1;
      stall_on  = 1'b0;
      dp_v      = 1'b0;
      dp_write  = 1'b0;
      dp_idx    = '0;
      wait_left = 0;
      gnt_wait  = 0;
      cycles    = 0;
      test_errs = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      repeat (16) @(posedge HCLK);
      @(negedge HCLK);
      HRESETn = 1'b1;

      check_true("bus request high after reset", !hbusreq);
      check_true("interrupt high after reset", !dmacintr);
      check_true("slave not ready after reset", hreadyout);
      check_val("m_htrans after reset", word_t'(TRANS_IDLE), word_t'(m_htrans));
      check_val("s_hresp after reset", word_t'(`HRESP_OKAY), word_t'(s_hresp));
      for (int i = 0; i < 5; i++)
         shadow[i] = $random(seed);
      shadow[4][`CH_EN_BIT] = 1'b0;   // keep the channel quiet
      reg_write(`DMAC_CONFIG_OFS, shadow[0]);
      reg_write(`DMAC_SRC_OFS, shadow[1]);
      reg_write(`DMAC_DST_OFS, shadow[2]);
      reg_write(`DMAC_CTRL_OFS, shadow[3]);
      reg_write(`DMAC_CHCFG_OFS, shadow[4]);
      readback_all("readback");
      end_test("readback");

      @(negedge HCLK);
      hsel   = 1'b1;
      htrans = TRANS_NONSEQ;
      hwrite = 1'b1;
      haddr  = 32'h200;
      @(negedge HCLK);
      hsel   = 1'b0;
      htrans = TRANS_IDLE;
      hwdata = 32'hffff_ffff;
      check_val("unmapped resp cycle 1", word_t'(`HRESP_ERROR), word_t'(s_hresp));
      check_true("hreadyout not low in first error cycle", !hreadyout);
      @(negedge HCLK);
      check_val("unmapped resp cycle 2", word_t'(`HRESP_ERROR), word_t'(s_hresp));
      check_true("hreadyout not high in second error cycle", hreadyout);
      readback_all("unmapped");
      end_test("unmapped");

      for (int bc = 0; bc < 4; bc++)
         run_copy($sformatf("copy_bc%0d", bc), burst_code_t'(bc), 1'b0);
      run_copy("backpressure", burst_code_t'(rand_below(4)), 1'b1);

      $display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
               fail_cnt);
      if (fail_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- sources.f
+incdir+logic
logic/dmac_pkg.sv
logic/dmac_reg_slave.sv
logic/dmac_channel_ctrl.sv
logic/dmac_burst_buffer.sv
logic/dmac_master_port.sv
logic/dmac_top.sv
test/dmac_assertions.sv
test/dmac_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DMA controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module dmac_tb -o dmac_sim \
   > build.log 2>&1 \
   && ./obj_dir/dmac_sim > sim.log 2>&1 \
   || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^=== PASS ===$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
